/* Bender.yml */
package:
  name: apple_memory

sources:
  - common/apple_mem_pkg.sv
  - logic/soft_switches.sv
  - shadow_mem/shadow_write_map.sv
  - shadow_mem/sdpram32.sv
  - shadow_mem/video_read_mux.sv
  - logic/apple_memory.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/apple_memory_assertions.sv
      - testbench/tb_apple_memory.sv

/* all.f */
common/apple_mem_pkg.sv
logic/soft_switches.sv
shadow_mem/shadow_write_map.sv
shadow_mem/sdpram32.sv
shadow_mem/video_read_mux.sv
logic/apple_memory.sv
testbench/tb_clock_gen.sv
testbench/apple_memory_assertions.sv
testbench/tb_apple_memory.sv

/* common/apple_mem_pkg.sv */
`default_nettype none

package apple_mem_pkg;

    // ----------------------------------------
    // Bus and shadow word widths
    // ----------------------------------------
    localparam int unsigned A2_ADDR_W  = 16;
    localparam int unsigned A2_DATA_W  = 8;
    localparam int unsigned VRAM_LANES = 4;

    typedef logic [A2_ADDR_W-1:0]            a2_addr_t;
    typedef logic [A2_DATA_W-1:0]            a2_data_t;
    typedef logic [A2_DATA_W*VRAM_LANES-1:0] vram_word_t;
    typedef logic [VRAM_LANES-1:0]           byte_en_t;

    // Shadow RAM word-address widths
    localparam int unsigned TEXT_ADDR_W  = 10;
    localparam int unsigned HIRES_ADDR_W = 12;

    // ----------------------------------------
    // Soft switch locations
    // ----------------------------------------
    localparam logic [11:0] SW_II_PAGE     = 12'hC05;
    localparam logic [11:0] SW_IIE_PAGE    = 12'hC00;
    localparam a2_addr_t    STATE_REG_ADDR = 16'hC068;

    // II display switches, index is address bits 3..1
    localparam int unsigned SW_TEXT  = 0;
    localparam int unsigned SW_MIXED = 1;
    localparam int unsigned SW_PAGE2 = 2;
    localparam int unsigned SW_HIRES = 3;
    localparam int unsigned SW_AN0   = 4;
    localparam int unsigned SW_AN1   = 5;
    localparam int unsigned SW_AN2   = 6;
    localparam int unsigned SW_AN3   = 7;

    // IIe memory switches
    localparam int unsigned SW_STORE80   = 0;
    localparam int unsigned SW_RAMRD     = 1;
    localparam int unsigned SW_RAMWRT    = 2;
    localparam int unsigned SW_INTCXROM  = 3;
    localparam int unsigned SW_ALTZP     = 4;
    localparam int unsigned SW_SLOTC3ROM = 5;
    localparam int unsigned SW_COL80     = 6;
    localparam int unsigned SW_ALTCHAR   = 7;

endpackage

`default_nettype wire

/* logic/apple_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module apple_memory
    import apple_mem_pkg::*;
(
    input  wire           a2bus_if,
    input  wire           arst_n_i,
    input  wire a2_addr_t addr_i,
    input  wire a2_data_t data_i,
    input  wire           rw_n_i,
    input  wire           phi1_posedge_i,
    input  wire           m2sel_n_i,
    input  wire           data_in_strobe_i,
    input  wire           m2b0_i,
    input  wire a2_addr_t video_address_i,

    output logic          text_mode_o,
    output logic          mixed_mode_o,
    output logic          page2_o,
    output logic          hires_mode_o,
    output logic [3:0]    an_o,
    output logic          store80_o,
    output logic          ramrd_o,
    output logic          ramwrt_o,
    output logic          intcxrom_o,
    output logic          altzp_o,
    output logic          slotc3rom_o,
    output logic          col80_o,
    output logic          altchar_o,
    output logic          aux_mem_o,
    output vram_word_t    video_data_o
);

    // Write side
    logic [TEXT_ADDR_W-1:0]  text_waddr;
    byte_en_t                text_be;
    logic                    text_we;
    logic [HIRES_ADDR_W-1:0] hires_waddr;
    byte_en_t                hires_be;
    logic                    main_we;
    logic                    aux_we;
    vram_word_t              wdata;

    // Read side
    logic [TEXT_ADDR_W-1:0]  text_raddr;
    logic [HIRES_ADDR_W-1:0] hires_raddr;
    vram_word_t              text_rdata;
    vram_word_t              main_rdata;
    vram_word_t              aux_rdata;

    // ----------------------------------------
    // Soft switches and write decode
    // ----------------------------------------
    soft_switches i_soft_switches (
        .a2bus_if       (a2bus_if),
        .arst_n_i       (arst_n_i),
        .addr_i         (addr_i),
        .data_i         (data_i),
        .rw_n_i         (rw_n_i),
        .phi1_posedge_i (phi1_posedge_i),
        .m2sel_n_i      (m2sel_n_i),
        .text_mode_o    (text_mode_o),
        .mixed_mode_o   (mixed_mode_o),
        .page2_o        (page2_o),
        .hires_mode_o   (hires_mode_o),
        .an_o           (an_o),
        .store80_o      (store80_o),
        .ramrd_o        (ramrd_o),
        .ramwrt_o       (ramwrt_o),
        .intcxrom_o     (intcxrom_o),
        .altzp_o        (altzp_o),
        .slotc3rom_o    (slotc3rom_o),
        .col80_o        (col80_o),
        .altchar_o      (altchar_o)
    );

    shadow_write_map i_shadow_write_map (
        .addr_i           (addr_i),
        .data_i           (data_i),
        .rw_n_i           (rw_n_i),
        .data_in_strobe_i (data_in_strobe_i),
        .m2b0_i           (m2b0_i),
        .store80_i        (store80_o),
        .page2_i          (page2_o),
        .hires_mode_i     (hires_mode_o),
        .ramwrt_i         (ramwrt_o),
        .altzp_i          (altzp_o),
        .aux_mem_o        (aux_mem_o),
        .text_waddr_o     (text_waddr),
        .text_be_o        (text_be),
        .text_we_o        (text_we),
        .hires_waddr_o    (hires_waddr),
        .hires_be_o       (hires_be),
        .main_we_o        (main_we),
        .aux_we_o         (aux_we),
        .wdata_o          (wdata)
    );

    // ----------------------------------------
    // Shadow RAMs
    // ----------------------------------------

    // Text, main and aux interleaved
    sdpram32 #(
        .ADDR_WIDTH (TEXT_ADDR_W)
    ) i_text_ram (
        .a2bus_if (a2bus_if),
        .waddr_i  (text_waddr),
        .wdata_i  (wdata),
        .we_i     (text_we),
        .be_i     (text_be),
        .raddr_i  (text_raddr),
        .rdata_o  (text_rdata)
    );

    // Hires main bank
    sdpram32 #(
        .ADDR_WIDTH (HIRES_ADDR_W)
    ) i_hires_main_ram (
        .a2bus_if (a2bus_if),
        .waddr_i  (hires_waddr),
        .wdata_i  (wdata),
        .we_i     (main_we),
        .be_i     (hires_be),
        .raddr_i  (hires_raddr),
        .rdata_o  (main_rdata)
    );

    // Hires aux bank
    sdpram32 #(
        .ADDR_WIDTH (HIRES_ADDR_W)
    ) i_hires_aux_ram (
        .a2bus_if (a2bus_if),
        .waddr_i  (hires_waddr),
        .wdata_i  (wdata),
        .we_i     (aux_we),
        .be_i     (hires_be),
        .raddr_i  (hires_raddr),
        .rdata_o  (aux_rdata)
    );

    video_read_mux i_video_read_mux (
        .a2bus_if        (a2bus_if),
        .arst_n_i        (arst_n_i),
        .video_address_i (video_address_i),
        .text_rdata_i    (text_rdata),
        .main_rdata_i    (main_rdata),
        .aux_rdata_i     (aux_rdata),
        .text_raddr_o    (text_raddr),
        .hires_raddr_o   (hires_raddr),
        .video_data_o    (video_data_o)
    );

endmodule

`default_nettype wire

/* logic/soft_switches.sv */
`timescale 1ns/10ps
`default_nettype none

module soft_switches
    import apple_mem_pkg::*;
(
    input  wire           a2bus_if,
    input  wire           arst_n_i,
    input  wire a2_addr_t addr_i,
    input  wire a2_data_t data_i,
    input  wire           rw_n_i,
    input  wire           phi1_posedge_i,
    input  wire           m2sel_n_i,

    output logic          text_mode_o,
    output logic          mixed_mode_o,
    output logic          page2_o,
    output logic          hires_mode_o,
    output logic [3:0]    an_o,
    output logic          store80_o,
    output logic          ramrd_o,
    output logic          ramwrt_o,
    output logic          intcxrom_o,
    output logic          altzp_o,
    output logic          slotc3rom_o,
    output logic          col80_o,
    output logic          altchar_o
);

    // Power-up state: text mode with annunciator 3 set
    localparam logic [7:0] II_RESET = 8'(1 << SW_TEXT) | 8'(1 << SW_AN3);

    logic [7:0] sw_ii_q;
    logic [7:0] sw_iie_q;
    logic       bus_access;
    logic       bus_write;
    logic       state_wr;

    // Only accesses on the motherboard side count
    assign bus_access = phi1_posedge_i && !m2sel_n_i;
    assign bus_write  = bus_access && !rw_n_i;
    assign state_wr   = bus_write && (addr_i == STATE_REG_ADDR);

    // Display switches toggle on reads and writes alike
    always_ff @(posedge a2bus_if or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sw_ii_q <= II_RESET;
        end else if (bus_access && (addr_i[15:4] == SW_II_PAGE)) begin
            sw_ii_q[addr_i[3:1]] <= addr_i[0];
        end else if (state_wr) begin
            sw_ii_q[SW_PAGE2] <= data_i[6];
        end
    end

    // Memory switches respond to writes only
    always_ff @(posedge a2bus_if or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sw_iie_q <= '0;
        end else if (bus_write && (addr_i[15:4] == SW_IIE_PAGE)) begin
            sw_iie_q[addr_i[3:1]] <= addr_i[0];
        end else if (state_wr) begin
            sw_iie_q[SW_RAMRD]    <= data_i[5];
            sw_iie_q[SW_RAMWRT]   <= data_i[4];
            sw_iie_q[SW_INTCXROM] <= data_i[0];
        end
    end

    // ----------------------------------------
    // Switch levels
    // ----------------------------------------
    assign text_mode_o  = sw_ii_q[SW_TEXT];
    assign mixed_mode_o = sw_ii_q[SW_MIXED];
    assign page2_o      = sw_ii_q[SW_PAGE2];
    assign hires_mode_o = sw_ii_q[SW_HIRES];
    assign an_o         = {sw_ii_q[SW_AN3], sw_ii_q[SW_AN2], sw_ii_q[SW_AN1], sw_ii_q[SW_AN0]};

    assign store80_o   = sw_iie_q[SW_STORE80];
    assign ramrd_o     = sw_iie_q[SW_RAMRD];
    assign ramwrt_o    = sw_iie_q[SW_RAMWRT];
    assign intcxrom_o  = sw_iie_q[SW_INTCXROM];
    assign altzp_o     = sw_iie_q[SW_ALTZP];
    assign slotc3rom_o = sw_iie_q[SW_SLOTC3ROM];
    assign col80_o     = sw_iie_q[SW_COL80];
    assign altchar_o   = sw_iie_q[SW_ALTCHAR];

endmodule

`default_nettype wire

/* shadow_mem/sdpram32.sv */
`timescale 1ns/10ps
`default_nettype none

module sdpram32
    import apple_mem_pkg::*;
#(
    parameter int unsigned ADDR_WIDTH = 10
) (
    input  wire                  a2bus_if,
    input  wire [ADDR_WIDTH-1:0] waddr_i,
    input  wire vram_word_t      wdata_i,
    input  wire                  we_i,
    input  wire byte_en_t        be_i,
    input  wire [ADDR_WIDTH-1:0] raddr_i,
    output vram_word_t           rdata_o
);

    localparam int unsigned DEPTH = 2 ** ADDR_WIDTH;

    vram_word_t mem [DEPTH];
    vram_word_t rdata_q;

    // Byte-lane write port
    always_ff @(posedge a2bus_if) begin
        if (we_i) begin
            for (int lane = 0; lane < VRAM_LANES; lane++) begin
                if (be_i[lane]) begin
                    mem[waddr_i][lane*A2_DATA_W +: A2_DATA_W] <=
                        wdata_i[lane*A2_DATA_W +: A2_DATA_W];
                end
            end
        end
    end

    // Read port runs every cycle, one cycle of latency
    always_ff @(posedge a2bus_if) begin
        rdata_q <= mem[raddr_i];
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* shadow_mem/shadow_write_map.sv */
`timescale 1ns/10ps
`default_nettype none

module shadow_write_map
    import apple_mem_pkg::*;
(
    input  wire a2_addr_t           addr_i,
    input  wire a2_data_t           data_i,
    input  wire                     rw_n_i,
    input  wire                     data_in_strobe_i,
    input  wire                     m2b0_i,
    input  wire                     store80_i,
    input  wire                     page2_i,
    input  wire                     hires_mode_i,
    input  wire                     ramwrt_i,
    input  wire                     altzp_i,

    output logic                    aux_mem_o,
    output logic [TEXT_ADDR_W-1:0]  text_waddr_o,
    output byte_en_t                text_be_o,
    output logic                    text_we_o,
    output logic [HIRES_ADDR_W-1:0] hires_waddr_o,
    output byte_en_t                hires_be_o,
    output logic                    main_we_o,
    output logic                    aux_we_o,
    output vram_word_t              wdata_o
);

    logic        is_write;
    logic        write_strobe;
    logic        e1;
    logic        in_text;
    logic        in_hires;
    logic [11:0] text_off;
    logic [13:0] hires_off;

    assign is_write     = !rw_n_i;
    assign write_strobe = is_write && data_in_strobe_i;

    // ----------------------------------------
    // Aux bank selection
    // ----------------------------------------
    always_comb begin
        if ((addr_i[15:9] == 7'b0000000) || (addr_i[15:14] == 2'b11)) begin
            // Zero page, stack and the $C0-$FF region
            aux_mem_o = altzp_i;
        end else if (addr_i[15:10] == 6'b000001) begin
            // Text page 1
            aux_mem_o = (store80_i && page2_i) || (!store80_i && ramwrt_i && is_write);
        end else if (addr_i[15:13] == 3'b001) begin
            // Hires page 1
            aux_mem_o = (store80_i && page2_i && hires_mode_i) ||
                        ((!store80_i || !hires_mode_i) && ramwrt_i && is_write);
        end else begin
            aux_mem_o = ramwrt_i && is_write;
        end
    end

    // Bus cards can also force the aux bank
    assign e1 = aux_mem_o || m2b0_i;

    // Shadowed ranges $0400-$0BFF and $2000-$5FFF
    assign in_text  = (addr_i[15:10] == 6'b000001) || (addr_i[15:10] == 6'b000010);
    assign in_hires = (addr_i[15:13] == 3'b001) || (addr_i[15:13] == 3'b010);

    // ----------------------------------------
    // Write offsets
    // ----------------------------------------

    // Main and aux bytes sit side by side in the text RAM
    assign text_off  = {!addr_i[10], addr_i[9:0], e1};
    assign hires_off = 14'({addr_i[15:13] - 3'd1, addr_i[12:0]});

    assign text_waddr_o  = text_off[11:2];
    assign text_be_o     = byte_en_t'(4'b0001 << text_off[1:0]);
    assign text_we_o     = write_strobe && in_text;

    assign hires_waddr_o = hires_off[13:2];
    assign hires_be_o    = byte_en_t'(4'b0001 << hires_off[1:0]);
    assign main_we_o     = write_strobe && in_hires && !e1;
    assign aux_we_o      = write_strobe && in_hires && e1;

    // The byte enable picks the lane, so the byte goes to all four
    assign wdata_o = {VRAM_LANES{data_i}};

endmodule

`default_nettype wire

/* shadow_mem/video_read_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module video_read_mux
    import apple_mem_pkg::*;
(
    input  wire                     a2bus_if,
    input  wire                     arst_n_i,
    input  wire a2_addr_t           video_address_i,
    input  wire vram_word_t         text_rdata_i,
    input  wire vram_word_t         main_rdata_i,
    input  wire vram_word_t         aux_rdata_i,

    output logic [TEXT_ADDR_W-1:0]  text_raddr_o,
    output logic [HIRES_ADDR_W-1:0] hires_raddr_o,
    output vram_word_t              video_data_o
);

    logic in_text;
    logic in_hires;
    logic text_q;
    logic hires_q;
    logic upper_q;

    // Pair aux and main bytes, aux in the higher byte of each pair
    function automatic vram_word_t interleave(input logic upper, input vram_word_t main_w,
                                              input vram_word_t aux_w);
        vram_word_t result;
        if (upper) begin
            result = {aux_w[31:24], main_w[31:24], aux_w[23:16], main_w[23:16]};
        end else begin
            result = {aux_w[15:8], main_w[15:8], aux_w[7:0], main_w[7:0]};
        end
        return result;
    endfunction

    assign in_text  = (video_address_i[15:10] == 6'b000001) ||
                      (video_address_i[15:10] == 6'b000010);
    assign in_hires = (video_address_i[15:13] == 3'b001) ||
                      (video_address_i[15:13] == 3'b010);

    // Text words hold two scanner bytes, hires words hold four bytes per bank
    assign text_raddr_o  = {!video_address_i[10], video_address_i[9:1]};
    assign hires_raddr_o = {!video_address_i[13], video_address_i[12:2]};

    // ----------------------------------------
    // Select follows the RAM read by a cycle
    // ----------------------------------------
    always_ff @(posedge a2bus_if or negedge arst_n_i) begin
        if (!arst_n_i) begin
            text_q  <= 1'b0;
            hires_q <= 1'b0;
            upper_q <= 1'b0;
        end else begin
            text_q  <= in_text;
            hires_q <= in_hires;
            upper_q <= video_address_i[1];
        end
    end

    always_comb begin
        if (text_q) begin
            video_data_o = text_rdata_i;
        end else if (hires_q) begin
            video_data_o = interleave(upper_q, main_rdata_i, aux_rdata_i);
        end else begin
            video_data_o = '0;
        end
    end

endmodule

`default_nettype wire

/* testbench/apple_memory_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module apple_memory_assertions
    import apple_mem_pkg::*;
(
    input wire             clk_i,
    input wire             arst_n_i,
    input wire a2_addr_t   addr_i,
    input wire             rw_n_i,
    input wire             m2sel_n_i,
    input wire [15:0]      switches_i,
    input wire             aux_mem_i,
    input wire a2_addr_t   video_address_i,
    input wire vram_word_t video_data_i
);

    logic        video_in_range;
    int unsigned fail_count = 0;

    assign video_in_range = ((video_address_i >= 16'h0400) && (video_address_i <= 16'h0BFF)) ||
                            ((video_address_i >= 16'h2000) && (video_address_i <= 16'h5FFF));

    // Switches only move on motherboard accesses
    switch_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        m2sel_n_i |=> $stable(switches_i))
        else begin
            $error("Soft switch changed after a cycle with m2sel_n high");
            fail_count++;
        end

    // Reads of $0800-$1FFF stay in main memory whatever ALTZP and RAMRD hold
    main_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rw_n_i && (addr_i[15:8] >= 8'h08) && (addr_i[15:8] <= 8'h1F)) |-> !aux_mem_i)
        else begin
            $error("aux_mem_o set on a read of pages $08-$1F");
            fail_count++;
        end

    video_blank: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !video_in_range |=> (video_data_i == '0))
        else begin
            $error("video_data_o not zero after a scanner address outside the displays");
            fail_count++;
        end

endmodule

bind apple_memory apple_memory_assertions i_apple_memory_assertions (
    .clk_i           (a2bus_if),
    .arst_n_i        (arst_n_i),
    .addr_i          (addr_i),
    .rw_n_i          (rw_n_i),
    .m2sel_n_i       (m2sel_n_i),
    .switches_i      ({altchar_o, col80_o, slotc3rom_o, altzp_o, intcxrom_o, ramwrt_o,
                       ramrd_o, store80_o, an_o, hires_mode_o, page2_o, mixed_mode_o,
                       text_mode_o}),
    .aux_mem_i       (aux_mem_o),
    .video_address_i (video_address_i),
    .video_data_i    (video_data_o)
);

`default_nettype wire

/* testbench/tb_apple_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_apple_memory
    import apple_mem_pkg::*;
();

    localparam int unsigned SEED         = 32'hd73b4842;
    localparam int unsigned DRIVE_DELAY  = 10;
    localparam int unsigned SETTLE_DELAY = 40;
    // Several times the roughly 700 cycles that the tests take
    localparam int unsigned TIMEOUT_CYCLES = 5000;

    logic       clk;
    logic       arst_n;
    a2_addr_t   addr;
    a2_data_t   data;
    logic       rw_n;
    logic       phi1_posedge;
    logic       m2sel_n;
    logic       data_in_strobe;
    logic       m2b0;
    a2_addr_t   video_address;

    logic       text_mode;
    logic       mixed_mode;
    logic       page2;
    logic       hires_mode;
    logic [3:0] an;
    logic       store80;
    logic       ramrd;
    logic       ramwrt;
    logic       intcxrom;
    logic       altzp;
    logic       slotc3rom;
    logic       col80;
    logic       altchar;
    logic       aux_mem;
    vram_word_t video_data;

    // Reference model state
    logic [7:0] ii_model;
    logic [7:0] iie_model;
    a2_data_t   main_model [a2_addr_t];
    a2_data_t   aux_model  [a2_addr_t];

    int unsigned cycle_count = 0;
    int unsigned check_count = 0;
    int unsigned error_count = 0;
    int unsigned test_count  = 0;

    tb_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (10)
    ) i_tb_clock_gen (
        .clk_o   (clk),
        .rst_n_o (arst_n)
    );

    apple_memory i_apple_memory (
        .a2bus_if         (clk),
        .arst_n_i         (arst_n),
        .addr_i           (addr),
        .data_i           (data),
        .rw_n_i           (rw_n),
        .phi1_posedge_i   (phi1_posedge),
        .m2sel_n_i        (m2sel_n),
        .data_in_strobe_i (data_in_strobe),
        .m2b0_i           (m2b0),
        .video_address_i  (video_address),
        .text_mode_o      (text_mode),
        .mixed_mode_o     (mixed_mode),
        .page2_o          (page2),
        .hires_mode_o     (hires_mode),
        .an_o             (an),
        .store80_o        (store80),
        .ramrd_o          (ramrd),
        .ramwrt_o         (ramwrt),
        .intcxrom_o       (intcxrom),
        .altzp_o          (altzp),
        .slotc3rom_o      (slotc3rom),
        .col80_o          (col80),
        .altchar_o        (altchar),
        .aux_mem_o        (aux_mem),
        .video_data_o     (video_data)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic in_shadow(input a2_addr_t a);
        return ((a >= 16'h0400) && (a <= 16'h0BFF)) || ((a >= 16'h2000) && (a <= 16'h5FFF));
    endfunction

    function automatic logic expect_aux(input a2_addr_t a, input logic rw_n_v);
        logic [7:0] page;
        logic       wr;
        logic       s80;
        logic       ramwrt_m;
        page     = a[15:8];
        wr       = !rw_n_v;
        s80      = iie_model[SW_STORE80];
        ramwrt_m = iie_model[SW_RAMWRT];
        if ((page <= 8'h01) || (page >= 8'hC0)) begin
            return iie_model[SW_ALTZP];
        end else if ((page >= 8'h04) && (page <= 8'h07)) begin
            return (s80 && ii_model[SW_PAGE2]) || (!s80 && ramwrt_m && wr);
        end else if ((page >= 8'h20) && (page <= 8'h3F)) begin
            return (s80 && ii_model[SW_PAGE2] && ii_model[SW_HIRES]) ||
                   ((!s80 || !ii_model[SW_HIRES]) && ramwrt_m && wr);
        end
        return ramwrt_m && wr;
    endfunction

    // Memory first, since the bank choice uses the switches before the edge
    function automatic void model_access(input a2_addr_t a, input a2_data_t d,
                                         input logic rw_n_v, input logic m2sel_n_v,
                                         input logic m2b0_v);
        if (!rw_n_v && in_shadow(a)) begin
            if (expect_aux(a, rw_n_v) || m2b0_v) begin
                aux_model[a] = d;
            end else begin
                main_model[a] = d;
            end
        end
        if (!m2sel_n_v) begin
            if (a[15:4] == 12'hC05) begin
                ii_model[a[3:1]] = a[0];
            end
            if (!rw_n_v && (a[15:4] == 12'hC00)) begin
                iie_model[a[3:1]] = a[0];
            end
            if (!rw_n_v && (a == 16'hC068)) begin
                ii_model[SW_PAGE2]      = d[6];
                iie_model[SW_RAMRD]     = d[5];
                iie_model[SW_RAMWRT]    = d[4];
                iie_model[SW_INTCXROM]  = d[0];
            end
        end
    endfunction

    // Text and hires both give an aux/main pair for each of two bytes
    function automatic vram_word_t expected_video(input a2_addr_t a);
        a2_addr_t pair;
        pair = {a[15:1], 1'b0};
        if (!in_shadow(a)) begin
            return '0;
        end
        return {aux_model[pair + 16'd1], main_model[pair + 16'd1],
                aux_model[pair], main_model[pair]};
    endfunction

    function automatic a2_data_t random_byte();
        return a2_data_t'($urandom);
    endfunction

    // ----------------------------------------
    // Bus drivers and checks
    // ----------------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        assert (got === expected) else begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic check_switches(input string where);
        check_value({where, ": II switches"},
                    {an, hires_mode, page2, mixed_mode, text_mode}, ii_model);
        check_value({where, ": IIe switches"},
                    {altchar, col80, slotc3rom, altzp, intcxrom, ramwrt, ramrd, store80},
                    iie_model);
    endtask

    // One bus cycle with phi1 and the data strobe, released after the edge
    task automatic bus_access(input a2_addr_t a, input a2_data_t d, input logic rw_n_v,
                              input logic m2sel_n_v, input logic m2b0_v);
        @(posedge clk);
        #DRIVE_DELAY;
        addr           = a;
        data           = d;
        rw_n           = rw_n_v;
        m2sel_n        = m2sel_n_v;
        m2b0           = m2b0_v;
        phi1_posedge   = 1'b1;
        data_in_strobe = 1'b1;
        model_access(a, d, rw_n_v, m2sel_n_v, m2b0_v);
        @(posedge clk);
        #DRIVE_DELAY;
        phi1_posedge   = 1'b0;
        data_in_strobe = 1'b0;
        rw_n           = 1'b1;
        m2sel_n        = 1'b1;
        m2b0           = 1'b0;
    endtask

    task automatic set_switch(input a2_addr_t a);
        bus_access(a, 8'h00, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic probe_aux(input a2_addr_t a, input logic rw_n_v);
        @(posedge clk);
        #DRIVE_DELAY;
        addr = a;
        rw_n = rw_n_v;
        #SETTLE_DELAY;
        check_value($sformatf("aux_mem_o for %h rw_n %b", a, rw_n_v), aux_mem,
                    expect_aux(a, rw_n_v));
    endtask

    task automatic scan_check(input a2_addr_t a);
        vram_word_t expected;
        expected = expected_video(a);
        @(posedge clk);
        #DRIVE_DELAY;
        video_address = a;
        @(posedge clk);
        #DRIVE_DELAY;
        check_value($sformatf("video_data_o for %h", a), video_data, expected);
        video_address = 16'h0000;
    endtask

    task automatic finish_test(input string name, input int unsigned errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_reset_state();
        int unsigned errors_before;
        errors_before = error_count;
        check_switches("after reset");
        check_value("video_data_o after reset", video_data, 32'h0);
        finish_test("reset state", errors_before);
    endtask

    task automatic test_display_switches();
        int unsigned errors_before;
        a2_addr_t    sw_addr;
        errors_before = error_count;
        for (int idx = 0; idx < 8; idx++) begin
            sw_addr = 16'hC050 + 16'(idx * 2);
            // Would flip the switch, but the access belongs to another device
            bus_access(sw_addr | 16'(!ii_model[idx]), random_byte(), 1'b1, 1'b1, 1'b0);
            check_switches("II with m2sel_n high");
            bus_access(sw_addr | 16'h1, random_byte(), idx[0], 1'b0, 1'b0);
            check_switches("II set");
            bus_access(sw_addr, random_byte(), !idx[0], 1'b0, 1'b0);
            check_switches("II clear");
        end
        finish_test("display switches", errors_before);
    endtask

    task automatic test_memory_switches();
        int unsigned errors_before;
        a2_addr_t    sw_addr;
        errors_before = error_count;
        for (int idx = 0; idx < 8; idx++) begin
            sw_addr = 16'hC000 + 16'(idx * 2);
            bus_access(sw_addr | 16'h1, random_byte(), 1'b1, 1'b0, 1'b0);
            check_switches("IIe read");
            bus_access(sw_addr | 16'h1, random_byte(), 1'b0, 1'b0, 1'b0);
            check_switches("IIe set");
            set_switch(sw_addr);
            check_switches("IIe clear");
        end
        // State register loads from random data
        for (int n = 0; n < 4; n++) begin
            bus_access(16'hC068, random_byte(), 1'b0, 1'b0, 1'b0);
            check_switches("state register");
        end
        finish_test("memory switches", errors_before);
    endtask

    task automatic apply_aux_switches(input logic [4:0] combo);
        if (iie_model[SW_ALTZP] != combo[0]) begin
            set_switch(16'hC008 | 16'(combo[0]));
        end
        if (iie_model[SW_STORE80] != combo[1]) begin
            set_switch(16'hC000 | 16'(combo[1]));
        end
        if (ii_model[SW_PAGE2] != combo[2]) begin
            set_switch(16'hC054 | 16'(combo[2]));
        end
        if (ii_model[SW_HIRES] != combo[3]) begin
            set_switch(16'hC056 | 16'(combo[3]));
        end
        if (iie_model[SW_RAMWRT] != combo[4]) begin
            set_switch(16'hC004 | 16'(combo[4]));
        end
        check_switches("aux rule setup");
    endtask

    task automatic test_aux_rule();
        int unsigned errors_before;
        a2_addr_t    probes [6] = '{16'h0012, 16'h0456, 16'h0900, 16'h2345,
                                    16'h8000, 16'hD000};
        errors_before = error_count;
        // Gray code order, so each step changes one switch
        for (int k = 0; k < 32; k++) begin
            apply_aux_switches(5'(k ^ (k >> 1)));
            foreach (probes[i]) begin
                probe_aux(probes[i], 1'b1);
                probe_aux(probes[i], 1'b0);
            end
        end
        finish_test("aux rule", errors_before);
    endtask

    task automatic test_text_shadow();
        int unsigned errors_before;
        a2_addr_t    bases [3] = '{16'h0400, 16'h07FE, 16'h0A10};
        errors_before = error_count;
        // STORE80 and RAMWRT off so m2b0 alone picks the bank
        set_switch(16'hC000);
        set_switch(16'hC004);
        foreach (bases[i]) begin
            for (int j = 0; j < 2; j++) begin
                bus_access(bases[i] + 16'(j), random_byte(), 1'b0, 1'b0, 1'b0);
                bus_access(bases[i] + 16'(j), random_byte(), 1'b0, 1'b0, 1'b1);
            end
            scan_check(bases[i]);
            scan_check(bases[i] + 16'd1);
        end
        finish_test("text shadow", errors_before);
    endtask

    task automatic test_hires_shadow();
        int unsigned errors_before;
        a2_addr_t    bases [4] = '{16'h2000, 16'h3FFC, 16'h4A40, 16'h5FFC};
        errors_before = error_count;
        foreach (bases[i]) begin
            for (int j = 0; j < 4; j++) begin
                bus_access(bases[i] + 16'(j), random_byte(), 1'b0, 1'b0, 1'b0);
                bus_access(bases[i] + 16'(j), random_byte(), 1'b0, 1'b0, 1'b1);
            end
            for (int j = 0; j < 4; j++) begin
                scan_check(bases[i] + 16'(j));
            end
        end
        scan_check(16'hC000);
        finish_test("hires shadow", errors_before);
    endtask

    initial begin
        void'($urandom(SEED));
        addr           = '0;
        data           = '0;
        rw_n           = 1'b1;
        phi1_posedge   = 1'b0;
        m2sel_n        = 1'b1;
        data_in_strobe = 1'b0;
        m2b0           = 1'b0;
        video_address  = '0;
        // TEXT and AN3 come up set
        ii_model       = 8'h81;
        iie_model      = 8'h00;

        @(posedge arst_n);
        test_reset_state();
        test_display_switches();
        test_memory_switches();
        test_aux_rule();
        test_text_shadow();
        test_hires_shadow();

        // Concurrent assertion failures from the bound checker
        error_count = error_count + i_apple_memory.i_apple_memory_assertions.fail_count;

        $display("Tests run: %0d, checks: %0d, errors: %0d",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 100,
    parameter int unsigned RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset drops just after an edge, like the other inputs
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire
